/* hdl/sensor_rx_pkg.sv */
`default_nettype none

package sensor_rx_pkg;

	// ----------------------------------------------------------------------
	// lane and pixel geometry
	// ----------------------------------------------------------------------
	localparam int lanes = 4;
	// deserializer output per lane per clock
	localparam int deser_width = 6;
	localparam int word_width = 12;
	// sync code spans three words, six deserializer words
	localparam int sync_width = 3 * word_width;

	// ----------------------------------------------------------------------
	// word types
	// ----------------------------------------------------------------------
	typedef logic [deser_width-1:0] deser_t;
	typedef logic [word_width-1:0] word_t;
	// lane 0 in the low bits
	typedef logic [lanes*word_width-1:0] pixel_t;
	// bit offset 0..5
	typedef logic [2:0] offset_t;

	// oldest word in the low bits, since bits arrive first-bit-lowest
	// 0xfff, then 0x000, then 0x000
	localparam logic [sync_width-1:0] sync_code = {12'h000, 12'h000, 12'hfff};

endpackage

`default_nettype wire

/* hdl/sensor_csr_pkg.sv */
`default_nettype none

package sensor_csr_pkg;

	// apb bus widths
	typedef logic [7:0] apb_addr_t;
	typedef logic [31:0] apb_data_t;

	// ----------------------------------------------------------------------
	// register map
	// ----------------------------------------------------------------------
	localparam apb_addr_t addr_ctrl = 8'h00;
	localparam apb_addr_t addr_status = 8'h04;
	localparam apb_addr_t addr_offset = 8'h08;
	localparam apb_addr_t addr_count = 8'h0C;

	// ctrl field positions, lane_en sits in 3:0
	localparam int ctrl_msb_bit = 4;
	localparam int ctrl_realign_bit = 8;

	// realign is a one cycle pulse
	typedef struct packed {
		logic [3:0] lane_en;
		logic msb_first;
		logic realign;
	} csr_ctrl_t;

endpackage

`default_nettype wire

/* hdl/lane_word_if.sv */
`timescale 1ns/1ps
`default_nettype none

// one lane of aligned words, aligner to merger
interface lane_word_if;

	sensor_rx_pkg::word_t word;
	// single cycle strobe, never back to back
	logic word_valid;
	// first word after a sync code
	logic sync;
	logic locked;

	modport src (output word, output word_valid, output sync, output locked);
	modport snk (input word, input word_valid, input sync, input locked);

endinterface

`default_nettype wire

/* hdl/lane_input_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module lane_input_stage (
	input  logic clk,
	input  logic reset,
	input  sensor_rx_pkg::deser_t [sensor_rx_pkg::lanes-1:0] lane_data,
	input  sensor_csr_pkg::csr_ctrl_t ctrl,
	output sensor_rx_pkg::deser_t [sensor_rx_pkg::lanes-1:0] lane_out,
	output logic [sensor_rx_pkg::lanes-1:0] lane_clear
);

	// ----------------------------------------------------------------------
	// lane registers
	// ----------------------------------------------------------------------
	// bits stay first-bit-lowest here
	// msb first words come out mirrored and are flipped per word in the merger,
	// a 6 bit chunk never lines up with a 12 bit word once lanes are skewed
	always_ff @(posedge clk) begin
		for (int i = 0; i < sensor_rx_pkg::lanes; i++) begin
			// idle lane held at zero
			if (ctrl.lane_en[i]) begin
				lane_out[i] <= lane_data[i];
			end else begin
				lane_out[i] <= '0;
			end
		end
	end

	// ----------------------------------------------------------------------
	// aligner clears
	// ----------------------------------------------------------------------
	// level for disabled lanes, one cycle for all on realign
	always_ff @(posedge clk) begin
		if (reset) begin
			lane_clear <= '0;
		end else begin
			lane_clear <= ~ctrl.lane_en | {sensor_rx_pkg::lanes{ctrl.realign}};
		end
	end

endmodule

`default_nettype wire

/* hdl/word_aligner.sv */
`timescale 1ns/1ps
`default_nettype none

module word_aligner (
	input  logic clk,
	input  logic reset,
	input  logic clear,
	input  sensor_rx_pkg::deser_t deser,
	lane_word_if.src lane,
	output sensor_rx_pkg::offset_t offset
);

	// last six deser words, newest in the high bits
	logic [sensor_rx_pkg::sync_width-1:0] shreg;
	logic [sensor_rx_pkg::sync_width+sensor_rx_pkg::deser_width-1:0] stream;
	logic [sensor_rx_pkg::sync_width-1:0] win [sensor_rx_pkg::deser_width];
	logic [sensor_rx_pkg::deser_width-1:0] hit;
	logic match;
	sensor_rx_pkg::offset_t match_offset;
	// word strobe phase, 2 cycles per word
	logic phase;
	logic lock_phase;
	logic locked_q;
	sensor_rx_pkg::offset_t offset_q;
	// strobes left until the first word after sync
	logic [1:0] sync_cnt;
	logic strobe;
	sensor_rx_pkg::word_t word_q;
	logic word_valid_q;
	logic sync_q;

	// ----------------------------------------------------------------------
	// bit windows
	// ----------------------------------------------------------------------
	assign stream = {deser, shreg};

	// window k is k bits older than the newest 36 bits
	for (genvar k = 0; k < sensor_rx_pkg::deser_width; k++) begin : g_win
		assign win[k] = stream[sensor_rx_pkg::sync_width + sensor_rx_pkg::deser_width - 1 - k
			-: sensor_rx_pkg::sync_width];
		assign hit[k] = (win[k] == sensor_rx_pkg::sync_code);
	end

	// lowest matching window wins
	always_comb begin
		match_offset = '0;
		for (int k = sensor_rx_pkg::deser_width - 1; k >= 0; k--) begin
			if (hit[k]) begin
				match_offset = sensor_rx_pkg::offset_t'(k);
			end
		end
	end

	assign match = (|hit) & ~clear;
	assign strobe = locked_q & ~clear & (phase == lock_phase);

	// ----------------------------------------------------------------------
	// lock and strobe control
	// ----------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			shreg <= '0;
			phase <= 1'b0;
			lock_phase <= 1'b0;
			locked_q <= 1'b0;
			offset_q <= '0;
			sync_cnt <= '0;
			word_valid_q <= 1'b0;
			sync_q <= 1'b0;
		end else begin
			shreg <= stream[$high(stream):sensor_rx_pkg::deser_width];
			phase <= ~phase;
			word_valid_q <= 1'b0;
			sync_q <= 1'b0;
			if (clear) begin
				locked_q <= 1'b0;
				sync_cnt <= '0;
			end
			if (strobe) begin
				// at count 2 the middle word is still the last 0x000 of the code
				word_valid_q <= (sync_cnt != 2'd2);
				sync_q <= (sync_cnt == 2'd1);
				if (sync_cnt != 2'd0) begin
					sync_cnt <= sync_cnt - 2'd1;
				end
			end
			// a fresh match overrides the countdown
			if (match) begin
				lock_phase <= phase;
				offset_q <= match_offset;
				locked_q <= 1'b1;
				sync_cnt <= 2'd2;
			end
		end
	end

	// middle word of the locked window
	always_ff @(posedge clk) begin
		if (strobe) begin
			word_q <= win[offset_q][2*sensor_rx_pkg::word_width-1 -: sensor_rx_pkg::word_width];
		end
	end

	assign lane.word = word_q;
	assign lane.word_valid = word_valid_q;
	assign lane.sync = sync_q;
	assign lane.locked = locked_q;
	assign offset = offset_q;

	// strobe spacing holds across relocks too
	a_valid_gap: assert property (@(posedge clk) disable iff (reset)
		lane.word_valid |=> !lane.word_valid);

	a_valid_locked: assert property (@(posedge clk) disable iff (reset)
		lane.word_valid |-> lane.locked);

endmodule

`default_nettype wire

/* hdl/pixel_merger.sv */
`timescale 1ns/1ps
`default_nettype none

module pixel_merger (
	input  logic clk,
	input  logic reset,
	lane_word_if.snk lanes_in [sensor_rx_pkg::lanes],
	input  sensor_csr_pkg::csr_ctrl_t ctrl,
	output sensor_rx_pkg::pixel_t pixel_data,
	output logic pixel_valid,
	output logic pixel_sync,
	output logic beat_pulse
);

	sensor_rx_pkg::word_t in_word [sensor_rx_pkg::lanes];
	logic [sensor_rx_pkg::lanes-1:0] in_valid;
	logic [sensor_rx_pkg::lanes-1:0] in_sync;
	logic [sensor_rx_pkg::lanes-1:0] in_locked;
	sensor_rx_pkg::word_t word_q [sensor_rx_pkg::lanes];
	logic [sensor_rx_pkg::lanes-1:0] sync_q;
	logic [sensor_rx_pkg::lanes-1:0] cap_q;
	logic [sensor_rx_pkg::lanes-1:0] cap_next;
	logic [sensor_rx_pkg::lanes-1:0] need;
	sensor_rx_pkg::pixel_t beat;
	logic beat_sync;
	logic done;

	// bit mirror of one word
	function automatic sensor_rx_pkg::word_t mirror(input sensor_rx_pkg::word_t w);
		sensor_rx_pkg::word_t r;
		for (int b = 0; b < sensor_rx_pkg::word_width; b++) begin
			r[b] = w[sensor_rx_pkg::word_width-1-b];
		end
		return r;
	endfunction

	// ----------------------------------------------------------------------
	// lane inputs
	// ----------------------------------------------------------------------
	for (genvar i = 0; i < sensor_rx_pkg::lanes; i++) begin : g_lane
		// msb first words arrive mirrored
		assign in_word[i] = ctrl.msb_first ? mirror(lanes_in[i].word) : lanes_in[i].word;
		assign in_valid[i] = lanes_in[i].word_valid & ctrl.lane_en[i];
		assign in_sync[i] = lanes_in[i].sync;
		assign in_locked[i] = lanes_in[i].locked;
	end

	// lanes that must deliver before a beat
	assign need = ctrl.lane_en & in_locked;
	assign cap_next = (cap_q | in_valid) & need;
	assign done = (need != '0) && ((cap_next & need) == need);

	// beat from held words, or the word arriving now
	always_comb begin
		beat = '0;
		beat_sync = 1'b0;
		for (int i = 0; i < sensor_rx_pkg::lanes; i++) begin
			if (need[i] && in_valid[i]) begin
				beat[i*sensor_rx_pkg::word_width +: sensor_rx_pkg::word_width] = in_word[i];
				beat_sync |= in_sync[i];
			end else if (need[i]) begin
				beat[i*sensor_rx_pkg::word_width +: sensor_rx_pkg::word_width] = word_q[i];
				beat_sync |= sync_q[i];
			end
		end
	end

	// ----------------------------------------------------------------------
	// capture flags and beat output
	// ----------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			cap_q <= '0;
			pixel_valid <= 1'b0;
			pixel_sync <= 1'b0;
			beat_pulse <= 1'b0;
		end else begin
			pixel_valid <= done;
			pixel_sync <= done & beat_sync;
			beat_pulse <= pixel_valid;
			if (done || ctrl.realign) begin
				cap_q <= '0;
			end else begin
				cap_q <= cap_next;
			end
		end
	end

	always_ff @(posedge clk) begin
		for (int i = 0; i < sensor_rx_pkg::lanes; i++) begin
			if (in_valid[i]) begin
				word_q[i] <= in_word[i];
				sync_q[i] <= in_sync[i];
			end
		end
		if (done) begin
			pixel_data <= beat;
		end
	end

	// a beat needs at least one lane enabled the cycle before
	a_no_lanes: assert property (@(posedge clk) disable iff (reset)
		pixel_valid |-> $past(ctrl.lane_en) != '0);

endmodule

`default_nettype wire

/* hdl/sensor_csr_apb.sv */
`timescale 1ns/1ps
`default_nettype none

module sensor_csr_apb (
	input  logic clk,
	input  logic reset,
	input  logic psel,
	input  logic penable,
	input  logic pwrite,
	input  sensor_csr_pkg::apb_addr_t paddr,
	input  sensor_csr_pkg::apb_data_t pwdata,
	output sensor_csr_pkg::apb_data_t prdata,
	output logic pready,
	output logic pslverr,
	input  logic [sensor_rx_pkg::lanes-1:0] locked,
	input  sensor_rx_pkg::offset_t [sensor_rx_pkg::lanes-1:0] offsets,
	input  logic beat_pulse,
	output sensor_csr_pkg::csr_ctrl_t ctrl
);

	logic access;
	logic mapped;
	logic wr_en;
	sensor_csr_pkg::apb_data_t beat_cnt;

	// no wait states
	assign pready = 1'b1;
	assign access = psel & penable;

	// ----------------------------------------------------------------------
	// read decode
	// ----------------------------------------------------------------------
	always_comb begin
		mapped = 1'b1;
		prdata = '0;
		case (paddr)
			sensor_csr_pkg::addr_ctrl: begin
				prdata[sensor_rx_pkg::lanes-1:0] = ctrl.lane_en;
				prdata[sensor_csr_pkg::ctrl_msb_bit] = ctrl.msb_first;
			end
			sensor_csr_pkg::addr_status: begin
				prdata[sensor_rx_pkg::lanes-1:0] = locked;
			end
			// 3 bits per lane, lane 0 lowest
			sensor_csr_pkg::addr_offset: begin
				prdata[$bits(offsets)-1:0] = offsets;
			end
			sensor_csr_pkg::addr_count: begin
				prdata = beat_cnt;
			end
			default: begin
				mapped = 1'b0;
			end
		endcase
	end

	// only ctrl is writable
	assign wr_en = access & pwrite & (paddr == sensor_csr_pkg::addr_ctrl);
	assign pslverr = access & (~mapped | (pwrite & (paddr != sensor_csr_pkg::addr_ctrl)));

	// ----------------------------------------------------------------------
	// control register
	// ----------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			ctrl.lane_en <= '1;
			ctrl.msb_first <= 1'b0;
			ctrl.realign <= 1'b0;
		end else begin
			// realign self clears
			ctrl.realign <= 1'b0;
			if (wr_en) begin
				ctrl.lane_en <= pwdata[sensor_rx_pkg::lanes-1:0];
				ctrl.msb_first <= pwdata[sensor_csr_pkg::ctrl_msb_bit];
				ctrl.realign <= pwdata[sensor_csr_pkg::ctrl_realign_bit];
			end
		end
	end

	// beats since last realign
	always_ff @(posedge clk) begin
		if (reset || ctrl.realign) begin
			beat_cnt <= '0;
		end else if (beat_pulse) begin
			beat_cnt <= beat_cnt + 1'b1;
		end
	end

	a_apb_enable: assert property (@(posedge clk) disable iff (reset)
		penable |-> psel);

endmodule

`default_nettype wire

/* hdl/sensor_rx_top.sv */
`timescale 1ns/1ps
`default_nettype none

module sensor_rx_top (
	input  logic clk,
	input  logic reset,
	input  sensor_rx_pkg::deser_t [sensor_rx_pkg::lanes-1:0] lane_data,
	input  logic psel,
	input  logic penable,
	input  logic pwrite,
	input  sensor_csr_pkg::apb_addr_t paddr,
	input  sensor_csr_pkg::apb_data_t pwdata,
	output sensor_csr_pkg::apb_data_t prdata,
	output logic pready,
	output logic pslverr,
	output sensor_rx_pkg::pixel_t pixel_data,
	output logic pixel_valid,
	output logic pixel_sync
);

	sensor_rx_pkg::deser_t [sensor_rx_pkg::lanes-1:0] lane_words;
	logic [sensor_rx_pkg::lanes-1:0] lane_clear;
	logic [sensor_rx_pkg::lanes-1:0] locked;
	sensor_rx_pkg::offset_t [sensor_rx_pkg::lanes-1:0] offsets;
	sensor_csr_pkg::csr_ctrl_t ctrl;
	logic beat_pulse;

	// one aligned word channel per lane
	lane_word_if lane_if [sensor_rx_pkg::lanes] ();

	lane_input_stage u_lane_input_stage (
		.clk        (clk),
		.reset      (reset),
		.lane_data  (lane_data),
		.ctrl       (ctrl),
		.lane_out   (lane_words),
		.lane_clear (lane_clear)
	);

	// ----------------------------------------------------------------------
	// per lane aligners
	// ----------------------------------------------------------------------
	for (genvar i = 0; i < sensor_rx_pkg::lanes; i++) begin : g_aligner
		word_aligner u_word_aligner (
			.clk    (clk),
			.reset  (reset),
			.clear  (lane_clear[i]),
			.deser  (lane_words[i]),
			.lane   (lane_if[i]),
			.offset (offsets[i])
		);
		assign locked[i] = lane_if[i].locked;
	end

	pixel_merger u_pixel_merger (
		.clk         (clk),
		.reset       (reset),
		.lanes_in    (lane_if),
		.ctrl        (ctrl),
		.pixel_data  (pixel_data),
		.pixel_valid (pixel_valid),
		.pixel_sync  (pixel_sync),
		.beat_pulse  (beat_pulse)
	);

	sensor_csr_apb u_sensor_csr_apb (
		.clk        (clk),
		.reset      (reset),
		.psel       (psel),
		.penable    (penable),
		.pwrite     (pwrite),
		.paddr      (paddr),
		.pwdata     (pwdata),
		.prdata     (prdata),
		.pready     (pready),
		.pslverr    (pslverr),
		.locked     (locked),
		.offsets    (offsets),
		.beat_pulse (beat_pulse),
		.ctrl       (ctrl)
	);

endmodule

`default_nettype wire

/* tests/tb_sensor_rx.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_sensor_rx;

	// ----------------------------------------------------------------------
	// stream geometry and run length
	// ----------------------------------------------------------------------
	localparam int clk_period = 100;
	localparam int idle_words = 4;
	localparam int pixel_words = 8;
	// trailing words let the last pixel word leave the window
	localparam int tail_words = 2;
	localparam int max_bits = 256;
	localparam int stream_bits = 5 + (idle_words + 3 + pixel_words + tail_words) * 12;
	localparam int stream_words = (stream_bits + 5) / 6;
	localparam int beat_wait = 64;
	localparam int apb_ops = 40;
	// three streams plus bus traffic and slack
	localparam int watchdog_cycles = 3 * (stream_words + beat_wait + 16) + 4 * apb_ops + 200;

	logic clk;
	logic reset;
	sensor_rx_pkg::deser_t [sensor_rx_pkg::lanes-1:0] lane_data;
	logic psel;
	logic penable;
	logic pwrite;
	sensor_csr_pkg::apb_addr_t paddr;
	sensor_csr_pkg::apb_data_t pwdata;
	sensor_csr_pkg::apb_data_t prdata;
	logic pready;
	logic pslverr;
	sensor_rx_pkg::pixel_t pixel_data;
	logic pixel_valid;
	logic pixel_sync;

	int checks;
	int errors;
	int beat_count;
	logic [31:0] lfsr_state;
	sensor_rx_pkg::pixel_t beats [$];
	logic sync_seen [$];
	// serialized bits per lane with the first sent bit at index 0
	logic lane_bits [sensor_rx_pkg::lanes][max_bits];
	int lane_len [sensor_rx_pkg::lanes];
	sensor_rx_pkg::word_t exp_words [sensor_rx_pkg::lanes][pixel_words];

	sensor_rx_top u_sensor_rx_top (
		.clk         (clk),
		.reset       (reset),
		.lane_data   (lane_data),
		.psel        (psel),
		.penable     (penable),
		.pwrite      (pwrite),
		.paddr       (paddr),
		.pwdata      (pwdata),
		.prdata      (prdata),
		.pready      (pready),
		.pslverr     (pslverr),
		.pixel_data  (pixel_data),
		.pixel_valid (pixel_valid),
		.pixel_sync  (pixel_sync)
	);

	always #(clk_period / 2) clk = ~clk;

	// beats sampled mid cycle
	always @(negedge clk) begin
		if (pixel_valid === 1'b1) begin
			beats.push_back(pixel_data);
			sync_seen.push_back(pixel_sync);
			beat_count++;
		end
	end

	// ----------------------------------------------------------------------
	// compare tasks
	// ----------------------------------------------------------------------
	task automatic check_data(input string name, input sensor_csr_pkg::apb_data_t exp,
			input sensor_csr_pkg::apb_data_t act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("Fail %0t %s expected %h got %h", $time, name, exp, act);
		end
	endtask

	task automatic check_pixel(input string name, input sensor_rx_pkg::pixel_t exp,
			input sensor_rx_pkg::pixel_t act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("Fail %0t %s expected %h got %h", $time, name, exp, act);
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("Fail %0t %s expected %b got %b", $time, name, exp, act);
		end
	endtask

	// ----------------------------------------------------------------------
	// apb master
	// ----------------------------------------------------------------------
	task automatic apb_write(input sensor_csr_pkg::apb_addr_t addr,
			input sensor_csr_pkg::apb_data_t data, output logic err);
		@(posedge clk);
		psel <= 1'b1;
		penable <= 1'b0;
		pwrite <= 1'b1;
		paddr <= addr;
		pwdata <= data;
		@(posedge clk);
		penable <= 1'b1;
		@(negedge clk);
		// zero wait states expected
		check_bit("pready", 1'b1, pready);
		err = pslverr;
		// write lands on this edge
		@(posedge clk);
		psel <= 1'b0;
		penable <= 1'b0;
		pwrite <= 1'b0;
	endtask

	task automatic apb_read(input sensor_csr_pkg::apb_addr_t addr,
			output sensor_csr_pkg::apb_data_t data, output logic err);
		@(posedge clk);
		psel <= 1'b1;
		penable <= 1'b0;
		pwrite <= 1'b0;
		paddr <= addr;
		@(posedge clk);
		penable <= 1'b1;
		@(negedge clk);
		check_bit("pready", 1'b1, pready);
		data = prdata;
		err = pslverr;
		@(posedge clk);
		psel <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic read_expect(input sensor_csr_pkg::apb_addr_t addr, input string name,
			input sensor_csr_pkg::apb_data_t exp);
		sensor_csr_pkg::apb_data_t data;
		logic err;
		apb_read(addr, data, err);
		check_data(name, exp, data);
		check_bit({name, " pslverr"}, 1'b0, err);
	endtask

	task automatic write_ctrl(input sensor_csr_pkg::apb_data_t data);
		logic err;
		apb_write(sensor_csr_pkg::addr_ctrl, data, err);
		check_bit("ctrl write pslverr", 1'b0, err);
	endtask

	// model count restarts on the realign edge like the counter
	task automatic clear_beats();
		beats.delete();
		sync_seen.delete();
		beat_count = 0;
	endtask

	// ----------------------------------------------------------------------
	// lane serializer model
	// ----------------------------------------------------------------------
	// galois lfsr over x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		if (s[0]) begin
			return (s >> 1) ^ 32'h8020_0003;
		end
		return s >> 1;
	endfunction

	// one lfsr step per bit
	function automatic sensor_rx_pkg::word_t take_word();
		sensor_rx_pkg::word_t w;
		for (int b = 0; b < sensor_rx_pkg::word_width; b++) begin
			w[b] = lfsr_state[0];
			lfsr_state = lfsr_next(lfsr_state);
		end
		return w;
	endfunction

	function automatic int lane_skew(input int l);
		case (l)
			0: return 0;
			1: return 1;
			2: return 3;
			default: return 5;
		endcase
	endfunction

	// sync start bit mod 6 picks the window that holds the whole code
	function automatic int window_offset(input int skew);
		int bit_pos;
		bit_pos = skew + idle_words * sensor_rx_pkg::word_width;
		return (sensor_rx_pkg::deser_width - (bit_pos % sensor_rx_pkg::deser_width))
			% sensor_rx_pkg::deser_width;
	endfunction

	task automatic append_word(input int l, input sensor_rx_pkg::word_t w, input logic msb);
		int idx;
		for (int b = 0; b < sensor_rx_pkg::word_width; b++) begin
			idx = msb ? sensor_rx_pkg::word_width - 1 - b : b;
			lane_bits[l][lane_len[l]] = w[idx];
			lane_len[l]++;
		end
	endtask

	// filler then idle words, sync code, pixel words and tail
	task automatic send_stream(input logic msb);
		int max_len;
		int nwords;
		sensor_rx_pkg::deser_t [sensor_rx_pkg::lanes-1:0] d;
		max_len = 0;
		for (int l = 0; l < sensor_rx_pkg::lanes; l++) begin
			for (int i = 0; i < max_bits; i++) begin
				lane_bits[l][i] = 1'b0;
			end
			lane_len[l] = lane_skew(l);
			for (int i = 0; i < idle_words; i++) begin
				append_word(l, 12'h555, msb);
			end
			append_word(l, 12'hfff, msb);
			append_word(l, 12'h000, msb);
			append_word(l, 12'h000, msb);
			for (int m = 0; m < pixel_words; m++) begin
				exp_words[l][m] = take_word();
				append_word(l, exp_words[l][m], msb);
			end
			for (int i = 0; i < tail_words; i++) begin
				append_word(l, 12'h555, msb);
			end
			if (lane_len[l] > max_len) begin
				max_len = lane_len[l];
			end
		end
		nwords = (max_len + sensor_rx_pkg::deser_width - 1) / sensor_rx_pkg::deser_width;
		for (int w = 0; w < nwords; w++) begin
			for (int l = 0; l < sensor_rx_pkg::lanes; l++) begin
				for (int b = 0; b < sensor_rx_pkg::deser_width; b++) begin
					d[l][b] = lane_bits[l][w * sensor_rx_pkg::deser_width + b];
				end
			end
			@(posedge clk);
			lane_data <= d;
		end
		@(posedge clk);
		lane_data <= '0;
	endtask

	// ----------------------------------------------------------------------
	// result checks
	// ----------------------------------------------------------------------
	task automatic check_beats(input logic [sensor_rx_pkg::lanes-1:0] mask);
		sensor_rx_pkg::pixel_t exp;
		for (int i = 0; i < beat_wait && beats.size() < pixel_words; i++) begin
			@(posedge clk);
		end
		if (beats.size() < pixel_words) begin
			errors++;
			$display("error: only %0d pixel beats arrived, %0d expected",
				beats.size(), pixel_words);
		end else begin
			for (int m = 0; m < pixel_words; m++) begin
				exp = '0;
				for (int l = 0; l < sensor_rx_pkg::lanes; l++) begin
					if (mask[l]) begin
						exp[l*sensor_rx_pkg::word_width +: sensor_rx_pkg::word_width] =
							exp_words[l][m];
					end
				end
				check_pixel("pixel_data", exp, beats[m]);
				check_bit("pixel_sync", (m == 0), sync_seen[m]);
			end
		end
	endtask

	// pixel_valid reaches the counter two cycles later
	task automatic check_count();
		repeat (4) @(posedge clk);
		read_expect(sensor_csr_pkg::addr_count, "count", beat_count);
	endtask

	// ----------------------------------------------------------------------
	// directed tests
	// ----------------------------------------------------------------------
	task automatic test_registers();
		sensor_csr_pkg::apb_data_t data;
		logic err;
		read_expect(sensor_csr_pkg::addr_ctrl, "ctrl", 32'h0000_000f);
		read_expect(sensor_csr_pkg::addr_status, "status", 32'h0);
		read_expect(sensor_csr_pkg::addr_count, "count", 32'h0);
		// realign bit set but reads back clear
		write_ctrl(32'h0000_011a);
		clear_beats();
		read_expect(sensor_csr_pkg::addr_ctrl, "ctrl", 32'h0000_001a);
		apb_read(8'h10, data, err);
		check_bit("unmapped read pslverr", 1'b1, err);
		apb_write(8'h10, 32'h1, err);
		check_bit("unmapped write pslverr", 1'b1, err);
		apb_write(sensor_csr_pkg::addr_status, 32'hf, err);
		check_bit("status write pslverr", 1'b1, err);
	endtask

	task automatic test_lock_and_pixels(input logic msb);
		sensor_csr_pkg::apb_data_t ctrl_val;
		sensor_csr_pkg::apb_data_t exp_off;
		ctrl_val = 32'h0000_010f;
		ctrl_val[4] = msb;
		write_ctrl(ctrl_val);
		clear_beats();
		send_stream(msb);
		read_expect(sensor_csr_pkg::addr_status, "status", 32'hf);
		exp_off = '0;
		for (int l = 0; l < sensor_rx_pkg::lanes; l++) begin
			exp_off[3*l +: 3] = sensor_rx_pkg::offset_t'(window_offset(lane_skew(l)));
		end
		read_expect(sensor_csr_pkg::addr_offset, "offset", exp_off);
		check_beats(4'hf);
		// all lanes off stops the zero beats
		ctrl_val[3:0] = 4'h0;
		ctrl_val[8] = 1'b0;
		write_ctrl(ctrl_val);
		check_count();
	endtask

	task automatic test_mask_realign();
		write_ctrl(32'h0000_0105);
		clear_beats();
		send_stream(1'b0);
		read_expect(sensor_csr_pkg::addr_status, "status", 32'h5);
		check_beats(4'h5);
		write_ctrl(32'h0000_0105);
		clear_beats();
		repeat (6) @(posedge clk);
		read_expect(sensor_csr_pkg::addr_status, "status", 32'h0);
		check_count();
	endtask

	// ----------------------------------------------------------------------
	// watchdog and main sequence
	// ----------------------------------------------------------------------
	initial begin
		#(watchdog_cycles * clk_period);
		$display("timeout: run did not finish within %0d cycles", watchdog_cycles);
		$display("Checks failed");
		$finish;
	end

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		lane_data = '0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		checks = 0;
		errors = 0;
		beat_count = 0;
		lfsr_state = 32'hf28e;
		repeat (4) @(posedge clk);
		reset <= 1'b0;
		test_registers();
		test_lock_and_pixels(1'b0);
		test_lock_and_pixels(1'b1);
		test_mask_realign();
		$display("summary: %0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* list.f */
hdl/sensor_rx_pkg.sv
hdl/sensor_csr_pkg.sv
hdl/lane_word_if.sv
hdl/lane_input_stage.sv
hdl/word_aligner.sv
hdl/pixel_merger.sv
hdl/sensor_csr_apb.sv
hdl/sensor_rx_top.sv
tests/tb_sensor_rx.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = tb_sensor_rx
FILELIST = list.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: compile
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "^All checks passed$$" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
